// File: icache_pkg.sv
package icache_pkg;

    localparam int ways       = 4;
    localparam int sets       = 16;
    localparam int line_words = 16;
    localparam int tag_bits   = 22;

    typedef enum logic [2:0] {
        idle,
        lookup,
        replace,
        refill,
        cacop_op,
        extra_ready
    } state_t;

    typedef enum logic [1:0] {
        store_tag   = 2'd0,
        index_inval = 2'd1,
        hit_inval   = 2'd2
    } cacop_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        uncache;
        logic [6:0]  exc;
        logic [1:0]  cacop_code;
    } cache_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic [6:0]  exc;
        logic        cacop_done;
    } cache_resp_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } mem_rd_t;

    typedef logic [ways-1:0] way_vec_t;

endpackage

// File: icache_ctrl.sv
module icache_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    valid,
    input  logic                    cacop_en,
    input  icache_pkg::cache_req_t  req,
    output logic                    cache_ready,
    output logic                    resp_valid,
    output icache_pkg::cache_resp_t resp,
    input  icache_pkg::way_vec_t    hit,
    input  icache_pkg::way_vec_t    victim,
    input  logic [31:0]             rd_word,
    input  logic                    fill_finish,
    input  logic [31:0]             unc_word,
    input  logic                    r_rdy,
    output logic                    r_req,
    output logic                    r_data_ready,
    output logic [31:0]             r_addr,
    output logic [7:0]              r_len,
    output logic [31:0]             arr_addr,
    output logic [31:0]             cmp_addr,
    output icache_pkg::way_vec_t    tagv_we,
    output icache_pkg::way_vec_t    mem_we,
    output icache_pkg::way_vec_t    touch,
    output logic                    tagv_clear
);
    import icache_pkg::*;

    state_t      state;
    state_t      state_nxt;
    state_t      take_state;
    cache_req_t  rbuf;
    logic [31:0] mbuf_addr;
    logic        mbuf_unc;
    logic        accept;
    logic        lookup_hit;
    way_vec_t    inv_way;

    assign accept     = cache_ready && (valid || cacop_en);
    assign lookup_hit = rbuf.exc == '0 && !rbuf.uncache && |hit;
    assign take_state = cacop_en ? cacop_op : (valid ? lookup : idle);

    // Arrays see the new address on the accepting edge.
    assign arr_addr = accept ? req.addr : rbuf.addr;
    assign cmp_addr = rbuf.addr;
    assign inv_way  = way_vec_t'(1) << rbuf.addr[1:0]; // Way index in low address bits.

    assign r_addr = mbuf_addr;
    assign r_len  = mbuf_unc ? 8'd0 : 8'(line_words - 1);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rbuf <= req;
        end
        if (state == lookup && state_nxt == replace) begin
            mbuf_addr <= rbuf.uncache ? rbuf.addr : {rbuf.addr[31:6], 6'b0};
            mbuf_unc  <= rbuf.uncache;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            idle, extra_ready: state_nxt = take_state;
            lookup: begin
                if (rbuf.exc != '0) begin
                    state_nxt = idle;
                end else if (!lookup_hit) begin
                    state_nxt = replace; // Miss or uncached.
                end else begin
                    state_nxt = take_state;
                end
            end
            replace:  state_nxt = r_rdy ? refill : replace;
            refill:   state_nxt = fill_finish ? extra_ready : refill;
            cacop_op: state_nxt = idle;
            default:  state_nxt = idle;
        endcase
    end

    always_comb begin
        cache_ready  = 1'b0;
        resp_valid   = 1'b0;
        resp         = '0;
        r_req        = 1'b0;
        r_data_ready = 1'b0;
        tagv_we      = '0;
        mem_we       = '0;
        touch        = '0;
        tagv_clear   = 1'b0;
        case (state)
            idle: cache_ready = 1'b1;
            lookup: begin
                if (rbuf.exc != '0) begin
                    resp_valid = 1'b1;
                    resp.exc   = rbuf.exc;
                end else if (lookup_hit) begin
                    resp_valid  = 1'b1;
                    resp.data   = rd_word;
                    touch       = hit;
                    cache_ready = 1'b1;
                end
            end
            replace: r_req = 1'b1;
            refill: begin
                r_data_ready = 1'b1;
                if (fill_finish && !mbuf_unc) begin
                    mem_we  = victim;
                    tagv_we = victim;
                    touch   = victim;
                end
            end
            cacop_op: begin
                resp_valid      = 1'b1;
                resp.cacop_done = 1'b1;
                resp.exc        = rbuf.exc;
                if (rbuf.exc == '0) begin
                    case (rbuf.cacop_code)
                        store_tag, index_inval: begin
                            tagv_clear = 1'b1;
                            tagv_we    = inv_way;
                        end
                        hit_inval: begin
                            tagv_clear = 1'b1;
                            tagv_we    = hit;
                        end
                        default: ;
                    endcase
                end
            end
            extra_ready: begin
                resp_valid  = 1'b1;
                cache_ready = 1'b1;
                resp.data   = mbuf_unc ? unc_word : rd_word;
            end
            default: ;
        endcase
    end

endmodule

// File: icache_tagv.sv
module icache_tagv (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [31:0]          arr_addr,
    input  logic [31:0]          cmp_addr,
    input  icache_pkg::way_vec_t tagv_we,
    input  logic                 tagv_clear,
    output icache_pkg::way_vec_t hit,
    output icache_pkg::way_vec_t valid_ways
);
    import icache_pkg::*;

    logic [tag_bits-1:0] tag_arr [ways][sets];
    way_vec_t            valid_arr [sets];
    logic [tag_bits-1:0] tag_q [ways];
    way_vec_t            valid_q;
    logic [3:0]          set_idx;
    logic [tag_bits-1:0] wr_tag;

    assign set_idx = arr_addr[9:6];
    assign wr_tag  = arr_addr[31:10];

    // A write also updates the read register of that way.
    always_ff @(posedge clk) begin
        for (int w = 0; w < ways; w++) begin
            if (tagv_we[w]) begin
                tag_arr[w][set_idx] <= wr_tag;
                tag_q[w]            <= wr_tag;
            end else begin
                tag_q[w] <= tag_arr[w][set_idx];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < sets; s++) begin
                valid_arr[s] <= '0;
            end
            valid_q <= '0;
        end else begin
            for (int w = 0; w < ways; w++) begin
                if (tagv_we[w]) begin
                    valid_arr[set_idx][w] <= !tagv_clear;
                    valid_q[w]            <= !tagv_clear;
                end else begin
                    valid_q[w] <= valid_arr[set_idx][w];
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < ways; w++) begin
            hit[w] = valid_q[w] && tag_q[w] == cmp_addr[31:10];
        end
    end

    assign valid_ways = valid_q;

endmodule

// File: icache_data.sv
module icache_data (
    input  logic                                    clk,
    input  logic [31:0]                             arr_addr,
    input  icache_pkg::way_vec_t                    hit,
    input  icache_pkg::way_vec_t                    mem_we,
    input  logic [icache_pkg::line_words-1:0][31:0] line,
    output logic [31:0]                             rd_word
);
    import icache_pkg::*;

    logic [31:0] mem [ways][sets][line_words];
    logic [31:0] rd_q [ways];
    logic [3:0]  set_idx;
    logic [3:0]  word_idx;

    assign set_idx  = arr_addr[9:6];
    assign word_idx = arr_addr[5:2];

    always_ff @(posedge clk) begin
        for (int w = 0; w < ways; w++) begin
            if (mem_we[w]) begin
                for (int i = 0; i < line_words; i++) begin
                    mem[w][set_idx][i] <= line[i];
                end
                rd_q[w] <= line[word_idx]; // New line shows on the next read.
            end else begin
                rd_q[w] <= mem[w][set_idx][word_idx];
            end
        end
    end

    // Hit is one-hot.
    always_comb begin
        rd_word = '0;
        for (int w = 0; w < ways; w++) begin
            if (hit[w]) begin
                rd_word = rd_word | rd_q[w];
            end
        end
    end

endmodule

// File: icache_lru.sv
module icache_lru (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [31:0]          arr_addr,
    input  icache_pkg::way_vec_t touch,
    input  icache_pkg::way_vec_t valid_ways,
    output icache_pkg::way_vec_t victim
);
    import icache_pkg::*;

    logic [ways-1:0][1:0] age [sets]; // 0 is most recent, 3 is oldest.
    logic [3:0]           set_q;
    logic [1:0]           touch_age;
    logic                 found;

    // Set follows the arrays' read address.
    always_ff @(posedge clk) begin
        set_q <= arr_addr[9:6];
    end

    always_comb begin
        touch_age = '0;
        for (int w = 0; w < ways; w++) begin
            if (touch[w]) begin
                touch_age = age[set_q][w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < sets; s++) begin
                for (int w = 0; w < ways; w++) begin
                    age[s][w] <= 2'(w);
                end
            end
        end else if (|touch) begin
            for (int w = 0; w < ways; w++) begin
                if (touch[w]) begin
                    age[set_q][w] <= '0;
                end else if (age[set_q][w] < touch_age) begin
                    age[set_q][w] <= age[set_q][w] + 2'd1;
                end
            end
        end
    end

    always_comb begin
        victim = '0;
        found  = 1'b0;
        for (int w = 0; w < ways; w++) begin
            if (!valid_ways[w] && !found) begin
                victim[w] = 1'b1; // Lowest invalid way first.
                found     = 1'b1;
            end
        end
        if (!found) begin
            for (int w = 0; w < ways; w++) begin
                victim[w] = age[set_q][w] == 2'(ways - 1);
            end
        end
    end

endmodule

// File: icache_refill.sv
module icache_refill (
    input  logic                                    clk,
    input  logic                                    rstn,
    input  logic                                    r_data_ready,
    input  logic                                    r_valid,
    input  icache_pkg::mem_rd_t                     rdata,
    output logic [icache_pkg::line_words-1:0][31:0] line,
    output logic [31:0]                             unc_word,
    output logic                                    fill_finish
);
    import icache_pkg::*;

    logic [$clog2(line_words)-1:0] beat_cnt;
    logic                          beat;

    assign beat = r_data_ready && r_valid;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_cnt    <= '0;
            fill_finish <= 1'b0;
        end else begin
            fill_finish <= beat && rdata.last;
            if (beat) begin
                beat_cnt <= rdata.last ? '0 : beat_cnt + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            line[beat_cnt] <= rdata.data;
            if (beat_cnt == '0) begin
                unc_word <= rdata.data; // Single beat of an uncached read.
            end
        end
    end

endmodule

// File: icache_top.sv
module icache_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    valid,
    input  logic                    cacop_en,
    input  icache_pkg::cache_req_t  req,
    output logic                    cache_ready,
    output logic                    resp_valid,
    output icache_pkg::cache_resp_t resp,
    output logic                    r_req,
    output logic [31:0]             r_addr,
    output logic [7:0]              r_len,
    input  logic                    r_rdy,
    output logic                    r_data_ready,
    input  logic                    r_valid,
    input  icache_pkg::mem_rd_t     rdata
);
    import icache_pkg::*;

    logic [31:0]                 arr_addr;
    logic [31:0]                 cmp_addr;
    way_vec_t                    hit;
    way_vec_t                    victim;
    way_vec_t                    valid_ways;
    way_vec_t                    tagv_we;
    way_vec_t                    mem_we;
    way_vec_t                    touch;
    logic                        tagv_clear;
    logic [31:0]                 rd_word;
    logic [31:0]                 unc_word;
    logic                        fill_finish;
    logic [line_words-1:0][31:0] line;

    icache_ctrl ctrl_i (
        .clk          (clk),
        .rstn         (rstn),
        .valid        (valid),
        .cacop_en     (cacop_en),
        .req          (req),
        .cache_ready  (cache_ready),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .hit          (hit),
        .victim       (victim),
        .rd_word      (rd_word),
        .fill_finish  (fill_finish),
        .unc_word     (unc_word),
        .r_rdy        (r_rdy),
        .r_req        (r_req),
        .r_data_ready (r_data_ready),
        .r_addr       (r_addr),
        .r_len        (r_len),
        .arr_addr     (arr_addr),
        .cmp_addr     (cmp_addr),
        .tagv_we      (tagv_we),
        .mem_we       (mem_we),
        .touch        (touch),
        .tagv_clear   (tagv_clear)
    );

    icache_tagv tagv_i (
        .clk        (clk),
        .rstn       (rstn),
        .arr_addr   (arr_addr),
        .cmp_addr   (cmp_addr),
        .tagv_we    (tagv_we),
        .tagv_clear (tagv_clear),
        .hit        (hit),
        .valid_ways (valid_ways)
    );

    icache_data data_i (
        .clk      (clk),
        .arr_addr (arr_addr),
        .hit      (hit),
        .mem_we   (mem_we),
        .line     (line),
        .rd_word  (rd_word)
    );

    icache_lru lru_i (
        .clk        (clk),
        .rstn       (rstn),
        .arr_addr   (arr_addr),
        .touch      (touch),
        .valid_ways (valid_ways),
        .victim     (victim)
    );

    icache_refill refill_i (
        .clk          (clk),
        .rstn         (rstn),
        .r_data_ready (r_data_ready),
        .r_valid      (r_valid),
        .rdata        (rdata),
        .line         (line),
        .unc_word     (unc_word),
        .fill_finish  (fill_finish)
    );

endmodule

// File: tb_icache_props.sv
module tb_icache_props (
    input logic               clk,
    input logic               rstn,
    input icache_pkg::state_t state,
    input logic               cache_ready,
    input logic               resp_valid,
    input logic               r_req,
    input logic               r_rdy
);
    import icache_pkg::*;

    // A read request is held until the memory takes it.
    req_held: assert property (@(posedge clk) disable iff (!rstn) r_req && !r_rdy |=> r_req)
        else $error("r_req dropped before r_rdy");

    no_resp_in_miss: assert property (@(posedge clk) disable iff (!rstn)
        (state == replace || state == refill) |-> !resp_valid)
        else $error("resp_valid raised during replace or refill");

    reset_exit: assert property (@(posedge clk) $rose(rstn) |-> cache_ready && !r_req)
        else $error("cache not ready or r_req high after reset");

endmodule

bind icache_ctrl tb_icache_props props_i (
    .clk         (clk),
    .rstn        (rstn),
    .state       (state),
    .cache_ready (cache_ready),
    .resp_valid  (resp_valid),
    .r_req       (r_req),
    .r_rdy       (r_rdy)
);

// File: tb_icache.sv
module tb_icache;
    import icache_pkg::*;

    typedef struct packed {
        cache_resp_t resp;
        logic        one_cycle; // Response due right after acceptance.
        logic [31:0] acc_cyc;
    } expect_t;

    logic        clk;
    logic        rstn;
    logic        valid;
    logic        cacop_en;
    cache_req_t  req;
    logic        cache_ready;
    logic        resp_valid;
    cache_resp_t resp;
    logic        r_req;
    logic [31:0] r_addr;
    logic [7:0]  r_len;
    logic        r_rdy;
    logic        r_data_ready;
    logic        r_valid;
    mem_rd_t     rdata;

    expect_t     exp_q[$];
    string       test_name;
    logic [31:0] cyc;
    logic [31:0] rng;
    logic [31:0] last_addr;
    logic [7:0]  last_len;
    logic        r_req_q     = 1'b0;
    int          bursts      = 0;
    int          checks      = 0;
    int          errors      = 0;
    int          stim_errors = 0;
    int          bus_errors  = 0;
    int          timeouts    = 0;

    icache_top dut_i (.*);

    // Memory contents as a fixed mix of the address bits.
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return ((a ^ 32'h5a5a_c3c3) * 32'h9e37_79b1) + {a[15:0], a[31:16]};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always #5 clk = !clk;

    always @(posedge clk) begin
        cyc <= rstn ? cyc + 32'd1 : 32'd0;
    end

    initial begin : memory_model
        logic [31:0] base;
        logic [7:0]  len;
        r_rdy   = 1'b0;
        r_valid = 1'b0;
        rdata   = '0;
        rng     = 32'd4;
        forever begin
            @(negedge clk);
            if (r_req) begin
                base = r_addr;
                len  = r_len;
                rng  = xorshift32(rng);
                repeat (rng[1:0]) @(negedge clk);
                r_rdy = 1'b1;
                if (r_data_ready) begin
                    $display("%s: r_data_ready high before the request was taken", test_name);
                    bus_errors++;
                end
                @(negedge clk);
                r_rdy = 1'b0;
                for (int b = 0; b <= int'(len); b++) begin
                    rng = xorshift32(rng);
                    repeat (rng[1:0]) @(negedge clk); // Gap between beats.
                    r_valid    = 1'b1;
                    rdata.data = mem_word(base + 32'(4 * b));
                    rdata.last = b == int'(len);
                    if (!r_data_ready) begin
                        $display("%s: beat %0d sent while r_data_ready was low", test_name, b);
                        bus_errors++;
                    end
                    @(negedge clk);
                    r_valid = 1'b0;
                end
            end
        end
    end

    always @(negedge clk) begin : compare
        expect_t e;
        if (rstn) begin
            if (r_req && !r_req_q) begin
                bursts    = bursts + 1;
                last_addr = r_addr;
                last_len  = r_len;
            end
            if (resp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("%s: response arrived with no request outstanding", test_name);
                    errors = errors + 1;
                end else begin
                    e      = exp_q.pop_front();
                    checks = checks + 1;
                    if (resp !== e.resp) begin
                        $display("ERR %s: resp expected %h actual %h", test_name, e.resp, resp);
                        errors = errors + 1;
                    end
                    if (e.one_cycle && cyc - e.acc_cyc != 32'd1) begin
                        $display("ERR %s: latency expected 1 actual %0d", test_name,
                                 cyc - e.acc_cyc);
                        errors = errors + 1;
                    end
                end
            end
        end
        r_req_q = r_req;
    end

    // Called on a falling edge and returns one falling edge after acceptance.
    task automatic send(input cache_req_t r, input logic cop, input cache_resp_t e,
                        input logic one_cycle);
        int n;
        n        = 0;
        req      = r;
        valid    = !cop;
        cacop_en = cop;
        while (!cache_ready && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!cache_ready) begin
            $display("%s: cache_ready stayed low, request for %h not taken", test_name, r.addr);
            timeouts++;
        end else begin
            exp_q.push_back('{resp: e, one_cycle: one_cycle, acc_cyc: cyc});
        end
        @(negedge clk);
        valid    = 1'b0;
        cacop_en = 1'b0;
    endtask

    task automatic read_word(input logic [31:0] addr, input logic unc, input logic one_cycle);
        send('{addr: addr, uncache: unc, exc: 7'd0, cacop_code: 2'd0}, 1'b0,
             '{data: mem_word(addr), exc: 7'd0, cacop_done: 1'b0}, one_cycle);
    endtask

    task automatic cache_op(input logic [31:0] addr, input cacop_t code);
        send('{addr: addr, uncache: 1'b0, exc: 7'd0, cacop_code: code}, 1'b1,
             '{data: 32'd0, exc: 7'd0, cacop_done: 1'b1}, 1'b1);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 300) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d responses never arrived", test_name, exp_q.size());
            timeouts++;
            exp_q.delete();
        end
    endtask

    task automatic check_bursts(input int want);
        if (bursts != want) begin
            $display("ERR %s: bursts expected %0d actual %0d", test_name, want, bursts);
            stim_errors++;
        end
    endtask

    task automatic check_burst_shape(input logic [7:0] len, input logic [31:0] addr);
        if (last_len != len) begin
            $display("ERR %s: r_len expected %0d actual %0d", test_name, len, last_len);
            stim_errors++;
        end
        if (last_addr != addr) begin
            $display("ERR %s: r_addr expected %h actual %h", test_name, addr, last_addr);
            stim_errors++;
        end
    endtask

    initial begin : stimulus
        clk       = 1'b0;
        rstn      = 1'b0;
        valid     = 1'b0;
        cacop_en  = 1'b0;
        req       = '0;
        test_name = "reset";
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        test_name = "cold_miss";
        read_word(32'h0000_1044, 1'b0, 1'b0);
        drain();
        check_bursts(1);
        check_burst_shape(8'd15, 32'h0000_1040);

        test_name = "hit_stream";
        for (int i = 0; i < line_words; i++) begin
            read_word(32'h0000_1040 + 32'(4 * i), 1'b0, 1'b1);
        end
        drain();
        check_bursts(1);

        test_name = "uncached";
        read_word(32'h0008_0124, 1'b1, 1'b0);
        drain();
        check_bursts(2);
        check_burst_shape(8'd0, 32'h0008_0124);
        read_word(32'h0008_0124, 1'b1, 1'b0);
        drain();
        check_bursts(3);

        // Tags 1 to 5 share set 5 so the fifth fill evicts tag 1.
        test_name = "lru";
        for (int t = 1; t <= 5; t++) begin
            read_word({22'(t), 4'd5, 6'h20}, 1'b0, 1'b0);
        end
        drain();
        check_bursts(8);
        read_word({22'd1, 4'd5, 6'h20}, 1'b0, 1'b0);
        drain();
        check_bursts(9);
        read_word({22'd5, 4'd5, 6'h20}, 1'b0, 1'b1);
        drain();
        check_bursts(9);

        test_name = "hit_inval";
        cache_op({22'd5, 4'd5, 6'h20}, hit_inval);
        read_word({22'd5, 4'd5, 6'h20}, 1'b0, 1'b0);
        drain();
        check_bursts(10);

        test_name = "index_inval";
        cache_op(32'h0000_1040, index_inval); // Low bits 0 pick way 0.
        read_word(32'h0000_1044, 1'b0, 1'b0);
        drain();
        check_bursts(11);

        test_name = "exception";
        send('{addr: 32'h0000_3000, uncache: 1'b0, exc: 7'h0b, cacop_code: 2'd0}, 1'b0,
             '{data: 32'd0, exc: 7'h0b, cacop_done: 1'b0}, 1'b1);
        drain();
        check_bursts(11);

        repeat (2) @(negedge clk);
        $display("responses %0d, errors compare %0d stimulus %0d bus %0d, timeouts %0d",
                 checks, errors, stim_errors, bus_errors, timeouts);
        if (errors == 0 && stim_errors == 0 && bus_errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
icache_pkg.sv
icache_ctrl.sv
icache_tagv.sv
icache_data.sv
icache_lru.sv
icache_refill.sv
icache_top.sv
tb_icache_props.sv
tb_icache.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_icache -o tb_icache_sim \
    && ./obj_dir/tb_icache_sim > sim.log 2>&1
grep -q "^STATUS: PASS$" sim.log 2>/dev/null && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
